// ==== Makefile ====
# Verilator build and run for the FFT tile testbench

VERILATOR ?= verilator
TOP       ?= tb_acc_fft_tile
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SOURCES   ?= $(wildcard src/*.sv) $(wildcard bench/*.sv)

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q '^RESULT: PASS$$'

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/tb_acc_fft_tile.sv ====
// Back-pressure packets stay at size code 1 or less so that one packet in flight fits the FIFO margin
`timescale 1ns/1ps
`default_nettype none

module tb_acc_fft_tile
   import acc_fft_pkg::*;
();

   logic                 clk_ctrl;
   logic                 clk_ctrl_rst_low;
   logic [TILE_ID_W-1:0] tile_id;
   logic                 in_valid;
   noc_beat_t            in_beat;
   logic                 in_ready;
   logic                 out_valid;
   noc_beat_t            out_beat;
   logic                 out_ready;

   logic [32:0] exp_q[$];    // {data, last}
   string       exp_name[$];
   logic [31:0] payload[$];
   int          check_errors;
   int          other_errors;
   int          words_sent;
   int          cycle_cnt;
   bit          fft_on;      // enable as the DUT should see it
   bit          saw_stall;
   bit          bp_done;

   acc_fft_tile acc_fft_tile_inst (
      .clk_ctrl         (clk_ctrl),
      .clk_ctrl_rst_low (clk_ctrl_rst_low),
      .tile_id          (tile_id),
      .in_valid         (in_valid),
      .in_beat          (in_beat),
      .in_ready         (in_ready),
      .out_valid        (out_valid),
      .out_beat         (out_beat),
      .out_ready        (out_ready)
   );

   initial clk_ctrl = 1'b0;
   always #10 clk_ctrl = ~clk_ctrl;

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] build_head(input logic long_pkt, input logic [5:0] src,
                                              input logic [3:0] size, input logic [5:0] tag);
      return {3'b000, long_pkt, 3'b000, 1'b0, src, 6'h00, size, 2'b00, tag};
   endfunction

   function automatic logic [31:0] build_route(input logic [1:0] code, input logic [5:0] dest);
      return {22'h0, code, 2'b00, dest};
   endfunction

   function automatic void push_beat(input string name, input logic [31:0] data,
                                     input logic last);
      exp_q.push_back({data, last});
      exp_name.push_back(name);
   endfunction

   // Reply header plus FFT of every block in payload
   function automatic void expect_packet(input string name, input logic [31:0] head,
                                         input logic [31:0] route);
      logic [2:0]  op;
      logic [5:0]  tag;
      logic [31:0] rep_route;
      logic [31:0] xr[4];
      logic [31:0] xi[4];
      logic [31:0] yr[4];
      logic [31:0] yi[4];
      int          nblk;
      case (route[9:8])
         2'b01: begin
            op  = OP_MPUT;
            tag = route[5:0];
         end
         2'b10: begin
            op  = OP_QPUT;
            tag = route[5:0];
         end
         default: begin
            op  = OP_MPUT;
            tag = 6'h00;
         end
      endcase
      rep_route = (route[9:8] == 2'b01) ? build_route(2'b10, head[23:18]) : 32'h0;
      push_beat(name, {3'b000, 1'b1, op, 1'b0, tile_id, 6'h00, head[11:8], 2'b00, tag}, 1'b0);
      push_beat(name, rep_route, 1'b0);
      nblk = 1 << head[11:8];
      for (int b = 0; b < nblk; b++) begin
         for (int p = 0; p < 4; p++) begin
            xr[p] = payload[8*b + 2*p];
            xi[p] = payload[8*b + 2*p + 1];
         end
         yr[0] = xr[0] + xr[1] + xr[2] + xr[3];
         yi[0] = xi[0] + xi[1] + xi[2] + xi[3];
         yr[2] = (xr[0] + xr[2]) - (xr[1] + xr[3]);
         yi[2] = (xi[0] + xi[2]) - (xi[1] + xi[3]);
         // -j(a + jb) = b - ja, with a + jb = x1 - x3
         yr[1] = (xr[0] - xr[2]) + (xi[1] - xi[3]);
         yi[1] = (xi[0] - xi[2]) - (xr[1] - xr[3]);
         yr[3] = (xr[0] - xr[2]) - (xi[1] - xi[3]);
         yi[3] = (xi[0] - xi[2]) + (xr[1] - xr[3]);
         for (int p = 0; p < 4; p++) begin
            push_beat(name, yr[p], 1'b0);
            push_beat(name, yi[p], (b == nblk - 1) && (p == 3));
         end
      end
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus and checking
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [32:0] expected,
                              input logic [32:0] actual);
      if (expected !== actual) begin
         check_errors++;
         $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      end
   endtask

   task automatic send_word(input logic [31:0] data, input logic last);
      @(negedge clk_ctrl);
      in_valid     = 1'b1;
      in_beat.data = data;
      in_beat.last = last;
      while (!in_ready) begin
         saw_stall = 1'b1;
         @(negedge clk_ctrl);
      end
      words_sent++;
   endtask

   task automatic stop_input();
      @(negedge clk_ctrl);
      in_valid = 1'b0;
   endtask

   task automatic fill_payload(input int size, input bit random_data);
      payload.delete();
      for (int i = 0; i < (8 << size); i++)
         payload.push_back(random_data ? $urandom : 32'(i) - 32'd3); // small, some negative
   endtask

   task automatic send_packet(input string name, input logic [31:0] head,
                              input logic [31:0] route);
      int n;
      n = payload.size();
      if (fft_on)
         expect_packet(name, head, route);
      send_word(head, 1'b0);
      send_word(route, 1'b0);
      for (int i = 0; i < n; i++)
         send_word(payload[i], i == n - 1);
   endtask

   task automatic toggle_enable();
      send_word(build_head(1'b0, 6'h01, 4'd0, 6'h00), 1'b0);
      send_word(FFT_EN_WORD, 1'b1);
      fft_on = !fft_on;
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0)
         @(negedge clk_ctrl);
      repeat (10) @(negedge clk_ctrl); // catch stray words
   endtask

   task automatic finish_run(input bit timed_out);
      $display("Errors: %0d value mismatches, %0d other failures", check_errors, other_errors);
      if (!timed_out && check_errors == 0 && other_errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   endtask

   always @(posedge clk_ctrl) begin : compare_outputs
      if (clk_ctrl_rst_low && out_valid) begin
         if (!out_ready) begin
            other_errors++;
            $display("Output word %h presented while out_ready was low", out_beat.data);
         end else if (exp_q.size() == 0) begin
            other_errors++;
            $display("Output word %h arrived when none was expected", out_beat.data);
         end else begin
            check_value(exp_name.pop_front(), exp_q.pop_front(), {out_beat.data, out_beat.last});
         end
      end
   end

   initial begin : watchdog
      cycle_cnt = 0;
      do begin
         @(posedge clk_ctrl);
         cycle_cnt++;
      end while (cycle_cnt <= 4 * words_sent + 200);
      other_errors++;
      $display("Timeout after %0d cycles with %0d words still expected", cycle_cnt, exp_q.size());
      finish_run(1'b1);
   end

   initial begin : main
      void'($urandom(32'hfbfa));
      check_errors     = 0;
      other_errors     = 0;
      words_sent       = 0;
      fft_on           = 1'b0;
      saw_stall        = 1'b0;
      bp_done          = 1'b0;
      clk_ctrl_rst_low = 1'b0;
      tile_id          = 6'h2a;
      in_valid         = 1'b0;
      in_beat          = '0;
      out_ready        = 1'b1;
      repeat (8) @(negedge clk_ctrl);
      clk_ctrl_rst_low = 1'b1;

      // Disabled after reset, packet must vanish
      fill_payload(0, 1'b0);
      send_packet("disabled_drop", build_head(1'b1, 6'h11, 4'd0, 6'h05),
                  build_route(2'b01, 6'h07));
      stop_input();
      repeat (40) @(negedge clk_ctrl);

      toggle_enable();
      fill_payload(0, 1'b0);
      send_packet("fwd_reply", build_head(1'b1, 6'h15, 4'd0, 6'h00),
                  build_route(2'b01, 6'h2c));
      stop_input();
      wait_drain();

      fill_payload(1, 1'b1);
      send_packet("pico_reply", build_head(1'b1, 6'($urandom), 4'd1, 6'($urandom)),
                  build_route(2'b10, 6'h1b));
      fill_payload(0, 1'b1);
      send_packet("default_reply_00", build_head(1'b1, 6'($urandom), 4'd0, 6'h3f),
                  build_route(2'b00, 6'h33));
      fill_payload(0, 1'b1);
      send_packet("default_reply_11", build_head(1'b1, 6'($urandom), 4'd0, 6'h01),
                  build_route(2'b11, 6'h0e));
      stop_input();
      wait_drain();

      fill_payload(2, 1'b1);
      send_packet("size2_random", build_head(1'b1, 6'($urandom), 4'd2, 6'($urandom)),
                  build_route(2'b01, 6'($urandom)));
      stop_input();
      wait_drain();

      // Back-to-back packets against a stalling sink
      saw_stall = 1'b0;
      fork
         begin
            for (int k = 0; k < 10; k++) begin
               fill_payload(int'($urandom_range(0, 1)), 1'b1);
               send_packet("backpressure",
                           build_head(1'b1, 6'($urandom), 4'(payload.size() / 16), 6'($urandom)),
                           build_route(2'($urandom), 6'($urandom)));
            end
            stop_input();
            bp_done = 1'b1;
         end
         begin
            @(negedge clk_ctrl);
            out_ready = 1'b0;
            repeat (160) @(negedge clk_ctrl); // long enough to fill the FIFOs
            while (!bp_done) begin
               out_ready = ~out_ready;
               repeat ($urandom_range(5, 30)) @(negedge clk_ctrl);
            end
            out_ready = 1'b1;
         end
      join
      wait_drain();
      check_value("backpressure_in_ready_low", 33'd1, 33'(saw_stall));

      toggle_enable(); // off again
      fill_payload(1, 1'b1);
      send_packet("disabled_again", build_head(1'b1, 6'h09, 4'd1, 6'h02),
                  build_route(2'b01, 6'h04));
      stop_input();
      repeat (60) @(negedge clk_ctrl);

      finish_run(1'b0);
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/acc_fft_pkg.sv
src/noc_decoder.sv
src/fft4_core.sv
src/sync_fifo.sv
src/noc_encoder.sv
src/acc_fft_tile.sv
bench/tb_acc_fft_tile.sv

// ==== src/acc_fft_pkg.sv ====
// Packet formats and sizes shared by the tile; blocks are fixed at 4 points, size codes up to 3
`default_nettype none

package acc_fft_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Sizes and codes
   ////////////////////////////////////////////////////////////////////////////

   localparam int WORD_W      = 32;
   localparam int BLOCK_PTS   = 4;
   localparam int BLOCK_WORDS = 2 * BLOCK_PTS; // re and im per point
   localparam int BLOCK_W     = BLOCK_WORDS * WORD_W;
   localparam int TILE_ID_W   = 6;

   localparam logic [2:0] OP_QPUT = 3'd3;
   localparam logic [2:0] OP_MPUT = 3'd4;

   localparam logic [WORD_W-1:0] FFT_EN_WORD = 32'h8000_0000; // Toggles enable

   localparam int HEAD_FIFO_DEPTH    = 16;
   localparam int BLOCK_FIFO_DEPTH   = 16;
   localparam int ALMOST_FULL_MARGIN = 5;  // Free entries left at almost full
   localparam int MAX_SIZE_CODE      = 3;

   typedef enum logic [1:0] {
      ROUTE_DEFAULT = 2'b00,
      ROUTE_FWD     = 2'b01,
      ROUTE_PICO    = 2'b10
   } route_code_t;

   ////////////////////////////////////////////////////////////////////////////
   // Header words and payload
   ////////////////////////////////////////////////////////////////////////////

   typedef struct packed {
      logic [2:0] spare_hi;
      logic       long_pkt;   // bit 28
      logic [2:0] opcode;
      logic       spare_op;
      logic [5:0] src_id;     // 23:18
      logic [5:0] spare_mid;
      logic [3:0] size_code;  // 11:8, log2 of block count
      logic [1:0] spare_lo;
      logic [5:0] tag;
   } noc_head_t;

   typedef struct packed {
      logic [21:0] spare_hi;
      route_code_t code;      // 9:8
      logic [1:0]  spare_lo;
      logic [5:0]  dest;
   } noc_route_t;

   typedef struct packed {
      logic [WORD_W-1:0] data;
      logic              last;
   } noc_beat_t;

   typedef struct packed {
      logic [WORD_W-1:0] re;
      logic [WORD_W-1:0] im;
   } cplx_t;

   typedef cplx_t [BLOCK_PTS-1:0] fft_block_t;

endpackage

`default_nettype wire

// ==== src/acc_fft_tile.sv ====
// Single clock domain; output words appear only in cycles where out_ready is already high
`timescale 1ns/1ps
`default_nettype none

module acc_fft_tile
   import acc_fft_pkg::*;
(
   input  logic                 clk_ctrl,
   input  logic                 clk_ctrl_rst_low,
   input  logic [TILE_ID_W-1:0] tile_id,
   input  logic                 in_valid,
   input  noc_beat_t            in_beat,
   output logic                 in_ready,
   output logic                 out_valid,
   output noc_beat_t            out_beat,
   input  logic                 out_ready
);

   logic              head_wr;
   logic [WORD_W-1:0] head_wdata;
   logic              head_rd;
   logic [WORD_W-1:0] head_rdata;
   logic              head_afull;
   logic              blk_valid;
   fft_block_t        blk_in;
   logic              res_valid;
   fft_block_t        res_data;
   logic              blk_rd;
   fft_block_t        blk_out;
   logic              blk_empty;
   logic              blk_afull;
   logic              fifo_afull;

   assign fifo_afull = head_afull | blk_afull;

   noc_decoder noc_decoder_inst (
      .clk_ctrl         (clk_ctrl),
      .clk_ctrl_rst_low (clk_ctrl_rst_low),
      .tile_id          (tile_id),
      .in_valid         (in_valid),
      .in_beat          (in_beat),
      .fifo_almost_full (fifo_afull),
      .in_ready         (in_ready),
      .head_wr          (head_wr),
      .head_word        (head_wdata),
      .blk_valid        (blk_valid),
      .blk_data         (blk_in)
   );

   fft4_core fft4_core_inst (
      .clk_ctrl         (clk_ctrl),
      .clk_ctrl_rst_low (clk_ctrl_rst_low),
      .blk_valid        (blk_valid),
      .blk_data         (blk_in),
      .res_valid        (res_valid),
      .res_data         (res_data)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Reply headers and transformed blocks
   ////////////////////////////////////////////////////////////////////////////

   sync_fifo #(.WIDTH(WORD_W), .DEPTH(HEAD_FIFO_DEPTH)) head_fifo_inst (
      .clk_ctrl         (clk_ctrl),
      .clk_ctrl_rst_low (clk_ctrl_rst_low),
      .wr               (head_wr),
      .wdata            (head_wdata),
      .rd               (head_rd),
      .rdata            (head_rdata),
      .empty            (),            // blocks trail their headers
      .almost_full      (head_afull)
   );

   sync_fifo #(.WIDTH(BLOCK_W), .DEPTH(BLOCK_FIFO_DEPTH)) blk_fifo_inst (
      .clk_ctrl         (clk_ctrl),
      .clk_ctrl_rst_low (clk_ctrl_rst_low),
      .wr               (res_valid),
      .wdata            (res_data),
      .rd               (blk_rd),
      .rdata            (blk_out),
      .empty            (blk_empty),
      .almost_full      (blk_afull)
   );

   noc_encoder noc_encoder_inst (
      .clk_ctrl         (clk_ctrl),
      .clk_ctrl_rst_low (clk_ctrl_rst_low),
      .out_ready        (out_ready),
      .head_word        (head_rdata),
      .blk_empty        (blk_empty),
      .blk_data         (blk_out),
      .head_rd          (head_rd),
      .blk_rd           (blk_rd),
      .out_valid        (out_valid),
      .out_beat         (out_beat)
   );

endmodule

`default_nettype wire

// ==== src/fft4_core.sv ====
// Integer 4-point FFT, wraps modulo 2^32 without scaling; fixed latency of two cycles
`timescale 1ns/1ps
`default_nettype none

module fft4_core
   import acc_fft_pkg::*;
(
   input  logic       clk_ctrl,
   input  logic       clk_ctrl_rst_low,
   input  logic       blk_valid,
   input  fft_block_t blk_data,
   output logic       res_valid,
   output fft_block_t res_data
);

   function automatic cplx_t c_add(input cplx_t a, input cplx_t b);
      cplx_t s;
      s.re = a.re + b.re;
      s.im = a.im + b.im;
      return s;
   endfunction

   function automatic cplx_t c_sub(input cplx_t a, input cplx_t b);
      cplx_t d;
      d.re = a.re - b.re;
      d.im = a.im - b.im;
      return d;
   endfunction

   logic  st1_valid;
   cplx_t sum02, dif02; // even pair butterfly
   cplx_t sum13, dif13; // odd pair butterfly

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         st1_valid <= 1'b0;
         res_valid <= 1'b0;
      end else begin
         st1_valid <= blk_valid;
         res_valid <= st1_valid;
      end
   end

   // Stage 1
   always_ff @(posedge clk_ctrl) begin
      if (blk_valid) begin
         sum02 <= c_add(blk_data[0], blk_data[2]);
         dif02 <= c_sub(blk_data[0], blk_data[2]);
         sum13 <= c_add(blk_data[1], blk_data[3]);
         dif13 <= c_sub(blk_data[1], blk_data[3]);
      end
   end

   // Stage 2, odd bins take dif13 rotated by -j
   always_ff @(posedge clk_ctrl) begin
      if (st1_valid) begin
         res_data[0]    <= c_add(sum02, sum13);
         res_data[2]    <= c_sub(sum02, sum13);
         res_data[1].re <= dif02.re + dif13.im;
         res_data[1].im <= dif02.im - dif13.re;
         res_data[3].re <= dif02.re - dif13.im;
         res_data[3].im <= dif02.im + dif13.re;
      end
   end

endmodule

`default_nettype wire

// ==== src/noc_decoder.sv ====
// Long packets are dropped while disabled; a short packet's second word must carry its last bit
`timescale 1ns/1ps
`default_nettype none

module noc_decoder
   import acc_fft_pkg::*;
(
   input  logic                 clk_ctrl,
   input  logic                 clk_ctrl_rst_low,
   input  logic [TILE_ID_W-1:0] tile_id,
   input  logic                 in_valid,
   input  noc_beat_t            in_beat,
   input  logic                 fifo_almost_full,
   output logic                 in_ready,
   output logic                 head_wr,
   output logic [WORD_W-1:0]    head_word,
   output logic                 blk_valid,
   output fft_block_t           blk_data
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_CTRL,   // second word of a short packet
      S_ROUTE,
      S_DATA,
      S_DROP    // skip to last
   } dec_state_t;

   dec_state_t  state;
   logic        fft_en;
   logic [2:0]  word_cnt;
   logic        first_data;
   logic        accept;
   noc_head_t   in_head;
   noc_route_t  in_route;
   noc_head_t   head_reg;
   noc_route_t  route_reg;
   noc_head_t   reply_head;
   noc_route_t  reply_route;

   assign in_head  = noc_head_t'(in_beat.data);
   assign in_route = noc_route_t'(in_beat.data);

   // Hold off new packets only at a packet boundary
   assign in_ready = !(state == S_IDLE && fifo_almost_full);
   assign accept   = in_valid && in_ready;

   ////////////////////////////////////////////////////////////////////////////
   // Reply header
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      reply_head           = '0;
      reply_head.long_pkt  = 1'b1;
      reply_head.src_id    = tile_id;
      reply_head.size_code = head_reg.size_code;
      case (in_route.code)
         ROUTE_FWD: begin
            reply_head.opcode = OP_MPUT;
            reply_head.tag    = in_route.dest;
         end
         ROUTE_PICO: begin
            reply_head.opcode = OP_QPUT;
            reply_head.tag    = in_route.dest;
         end
         default: reply_head.opcode = OP_MPUT; // tag stays 0
      endcase

      reply_route = '0;
      if (route_reg.code == ROUTE_FWD) begin
         reply_route.code = ROUTE_PICO;
         reply_route.dest = head_reg.src_id; // back to the sender
      end else begin
         reply_route.code = ROUTE_DEFAULT;
      end
   end

   assign head_wr   = accept && (state == S_ROUTE || (state == S_DATA && first_data));
   assign head_word = (state == S_ROUTE) ? WORD_W'(reply_head) : WORD_W'(reply_route);

   ////////////////////////////////////////////////////////////////////////////
   // Packet FSM
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         state      <= S_IDLE;
         fft_en     <= 1'b0;
         word_cnt   <= '0;
         first_data <= 1'b0;
         blk_valid  <= 1'b0;
      end else begin
         blk_valid <= 1'b0;
         if (accept) begin
            case (state)
               S_IDLE: begin
                  if (!in_head.long_pkt)
                     state <= S_CTRL;
                  else if (fft_en)
                     state <= S_ROUTE;
                  else if (!in_beat.last)
                     state <= S_DROP;
               end
               S_CTRL: begin
                  if (in_beat.data == FFT_EN_WORD)
                     fft_en <= !fft_en;
                  state <= S_IDLE;
               end
               S_ROUTE: begin
                  state      <= S_DATA;
                  word_cnt   <= '0;
                  first_data <= 1'b1;
               end
               S_DATA: begin
                  first_data <= 1'b0;
                  word_cnt   <= word_cnt + 3'd1;
                  if (word_cnt == 3'(BLOCK_WORDS - 1))
                     blk_valid <= 1'b1; // block complete
                  if (in_beat.last)
                     state <= S_IDLE;
               end
               S_DROP: if (in_beat.last) state <= S_IDLE;
               default: state <= S_IDLE;
            endcase
         end
      end
   end

   // Header capture and block assembly
   always_ff @(posedge clk_ctrl) begin
      if (accept) begin
         case (state)
            S_IDLE:  head_reg  <= in_head;
            S_ROUTE: route_reg <= in_route;
            S_DATA: begin
               if (word_cnt[0])
                  blk_data[word_cnt[2:1]].im <= in_beat.data;
               else
                  blk_data[word_cnt[2:1]].re <= in_beat.data;
            end
            default: ;
         endcase
      end
   end

   // Encoder shifts by the size code, so larger codes would wrap its block count
   a_size_code: assert property (@(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low)
      state == S_ROUTE |-> head_reg.size_code <= MAX_SIZE_CODE);

endmodule

`default_nettype wire

// ==== src/noc_encoder.sv ====
// Expects both reply-header words queued before the first block; sends only while out_ready
`timescale 1ns/1ps
`default_nettype none

module noc_encoder
   import acc_fft_pkg::*;
(
   input  logic              clk_ctrl,
   input  logic              clk_ctrl_rst_low,
   input  logic              out_ready,
   input  logic [WORD_W-1:0] head_word,
   input  logic              blk_empty,
   input  fft_block_t        blk_data,
   output logic              head_rd,
   output logic              blk_rd,
   output logic              out_valid,
   output noc_beat_t         out_beat
);

   typedef enum logic [1:0] {
      E_IDLE,   // first header word goes out here
      E_HEAD2,
      E_DATA
   } enc_state_t;

   enc_state_t state;
   logic [2:0] word_cnt;
   logic [3:0] blk_left;
   noc_head_t  first_head;
   cplx_t      cur_pt;

   assign first_head = noc_head_t'(head_word);
   assign cur_pt     = blk_data[word_cnt[2:1]];

   always_comb begin
      head_rd   = 1'b0;
      blk_rd    = 1'b0;
      out_valid = 1'b0;
      out_beat  = '0;
      case (state)
         E_IDLE, E_HEAD2: begin
            if (out_ready && (state == E_HEAD2 || !blk_empty)) begin
               head_rd       = 1'b1;
               out_valid     = 1'b1;
               out_beat.data = head_word;
            end
         end
         E_DATA: begin
            // Stall between blocks until the next one lands
            if (out_ready && !blk_empty) begin
               out_valid     = 1'b1;
               out_beat.data = word_cnt[0] ? cur_pt.im : cur_pt.re;
               if (word_cnt == 3'(BLOCK_WORDS - 1)) begin
                  blk_rd        = 1'b1;
                  out_beat.last = (blk_left == 4'd1);
               end
            end
         end
         default: ;
      endcase
   end

   // State advances only on a sent word
   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         state    <= E_IDLE;
         word_cnt <= '0;
         blk_left <= '0;
      end else if (out_valid) begin
         case (state)
            E_IDLE: begin
               blk_left <= 4'd1 << first_head.size_code;
               state    <= E_HEAD2;
            end
            E_HEAD2: begin
               word_cnt <= '0;
               state    <= E_DATA;
            end
            E_DATA: begin
               word_cnt <= word_cnt + 3'd1;
               if (blk_rd)
                  blk_left <= blk_left - 4'd1;
               if (out_beat.last)
                  state <= E_IDLE;
            end
            default: state <= E_IDLE;
         endcase
      end
   end

   // Headers and blocks must stay paired across the two FIFOs
   a_head_aligned: assert property (@(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low)
      state == E_IDLE && out_valid |-> first_head.long_pkt);

endmodule

`default_nettype wire

// ==== src/sync_fifo.sv ====
// Show-ahead FIFO; writing when full or reading when empty is illegal and not guarded
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
   import acc_fft_pkg::*;
#(
   parameter int WIDTH = 32,
   parameter int DEPTH = 16
) (
   input  logic             clk_ctrl,
   input  logic             clk_ctrl_rst_low,
   input  logic             wr,
   input  logic [WIDTH-1:0] wdata,
   input  logic             rd,
   output logic [WIDTH-1:0] rdata,
   output logic             empty,
   output logic             almost_full
);

   logic [WIDTH-1:0]         mem [DEPTH];
   logic [$clog2(DEPTH)-1:0] wr_ptr;
   logic [$clog2(DEPTH)-1:0] rd_ptr;
   logic [$clog2(DEPTH):0]   count;

   assign rdata       = mem[rd_ptr]; // head entry always visible
   assign empty       = (count == 0);
   assign almost_full = (DEPTH - int'(count)) <= ALMOST_FULL_MARGIN;

   always_ff @(posedge clk_ctrl) begin
      if (wr)
         mem[wr_ptr] <= wdata;
   end

   always_ff @(posedge clk_ctrl) begin
      if (!clk_ctrl_rst_low) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (wr)
            wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
         if (rd)
            rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
         case ({wr, rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ; // both or neither
         endcase
      end
   end

   a_no_overflow: assert property (@(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low)
      wr |-> count != DEPTH);
   a_no_underflow: assert property (@(posedge clk_ctrl) disable iff (!clk_ctrl_rst_low)
      rd |-> !empty);

endmodule

`default_nettype wire
